// ==== Makefile ====
# Verilator build and run of the TLB testbench

SRCS := $(shell cat filelist.f)

.PHONY: run clean

run: obj_dir/Vtb_tlb
	./obj_dir/Vtb_tlb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_tlb: filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_tlb -f filelist.f -o Vtb_tlb

clean:
	rm -rf obj_dir sim.log

// ==== design/tlb_fill_ctrl.sv ====
`timescale 1ns/1ps

module tlb_fill_ctrl
#(
    parameter int num_sets = 64,
    parameter int num_ways = 4
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                inval,
    input  logic                init_done,
    input  logic                fill_en,
    input  tlb_pkg::va_page_t   fill_va,
    input  tlb_pkg::pa_page_t   fill_pa,
    output logic                fill_rdy,
    output logic [num_ways-1:0] wr_en,
    output tlb_pkg::va_page_t   wr_va,
    output tlb_pkg::pa_page_t   wr_pa
);

    import tlb_pkg::*;

    localparam int idx_bits = $clog2(num_sets);

    fill_state_t         state;
    logic [1:0]          bubble_cnt;
    logic                repl_req;
    logic                repl_ack;
    logic [num_ways-1:0] repl_way_vec;
    logic [num_ways-1:0] victim_vec;

    // ==============================
    // Fill FSM
    // ==============================

    // New fills only while idle and with all RAM copies swept
    assign fill_rdy = (state == fill_idle) && init_done;

    // An invalidate drops any fill in progress, since the sweep is about
    // to take over the RAM write ports
    always_ff @(posedge clk)
    begin
        if (reset || inval)
        begin
            state      <= fill_idle;
            bubble_cnt <= '0;
        end
        else
        begin
            case (state)
                fill_idle:
                begin
                    if (fill_en && fill_rdy)
                    begin
                        state <= fill_req_way;
                    end
                end
                fill_req_way:
                begin
                    state <= fill_recv_way;
                end
                fill_recv_way:
                begin
                    if (repl_ack)
                    begin
                        state <= fill_insert;
                    end
                end
                fill_insert:
                begin
                    state      <= fill_bubble;
                    bubble_cnt <= '0;
                end
                fill_bubble:
                begin
                    // Four quiet cycles before the next fill is taken
                    bubble_cnt <= bubble_cnt + 1'b1;
                    if (bubble_cnt == 2'd3)
                    begin
                        state <= fill_idle;
                    end
                end
                default:
                begin
                    state <= fill_idle;
                end
            endcase
        end
    end

    // Request and victim are held until the write cycle
    always_ff @(posedge clk)
    begin
        if ((state == fill_idle) && fill_en && fill_rdy)
        begin
            wr_va <= fill_va;
            wr_pa <= fill_pa;
        end
        if (repl_ack)
        begin
            victim_vec <= repl_way_vec;
        end
    end

    // One write cycle, broadcast to the same way in both lookup copies
    assign wr_en    = (state == fill_insert) ? victim_vec : '0;
    assign repl_req = (state == fill_req_way);

    tlb_repl_select
    #(
        .num_sets (num_sets),
        .num_ways (num_ways)
    )
    u_repl
    (
        .clk          (clk),
        .reset        (reset),
        .inval        (inval),
        .repl_req     (repl_req),
        .repl_idx     (wr_va[idx_bits-1:0]),
        .repl_ack     (repl_ack),
        .repl_way_vec (repl_way_vec)
    );

    // The page walker keeps fill_en low until fill_rdy returns
    a_fill_handshake: assert property (@(posedge clk) disable iff (reset)
        $rose(fill_en) |-> fill_rdy)
        else $error("tlb_fill_ctrl fill_en raised while fill_rdy was low");

endmodule

// ==== design/tlb_lookup_pipe.sv ====
`timescale 1ns/1ps

module tlb_lookup_pipe
#(
    parameter int num_sets = 64,
    parameter int num_ways = 4
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              inval,
    input  logic              lookup_en,
    input  tlb_pkg::va_page_t lookup_va,
    input  logic [num_ways-1:0] wr_en,
    input  tlb_pkg::va_page_t wr_va,
    input  tlb_pkg::pa_page_t wr_pa,
    output logic              init_done,
    output logic              lookup_valid,
    output logic              lookup_miss,
    output tlb_pkg::pa_page_t lookup_pa
);

    import tlb_pkg::*;

    // The index is the low part of the page index and the tag the rest
    localparam int idx_bits   = $clog2(num_sets);
    localparam int tag_bits   = va_page_bits - idx_bits;
    // Entry layout is valid bit, then tag, then physical page
    localparam int entry_bits = 1 + tag_bits + pa_page_bits;

    typedef logic [idx_bits-1:0]   idx_t;
    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [entry_bits-1:0] entry_t;

    logic [num_ways-1:0] way_done;
    entry_t              rdata [num_ways];
    entry_t              wdata;
    idx_t                raddr;
    idx_t                waddr;

    // Lookup valid chain through the four stages
    logic vld_s1;
    logic vld_s2;
    logic vld_s3;
    logic vld_s4;

    // The page index is only needed until the tag compare
    va_page_t va_s1;
    va_page_t va_s2;

    // Per way XOR of the tags, with the inverted valid bit on top
    logic [tag_bits:0]   xor_q [num_ways];
    logic [num_ways-1:0] hit_vec;
    pa_page_t            pa_s3 [num_ways];
    pa_page_t            pa_s4 [num_ways];
    pa_page_t            hit_pa;

    // ==============================
    // Storage, one copy per way
    // ==============================

    // Every fill writes a live entry, the sweep is the only way to clear one
    assign wdata = {1'b1, tag_t'(wr_va[va_page_bits-1:idx_bits]), wr_pa};
    assign waddr = wr_va[idx_bits-1:0];
    assign raddr = lookup_va[idx_bits-1:0];

    for (genvar w = 0; w < num_ways; w++)
    begin : g_way
        tlb_way_ram
        #(
            .num_sets   (num_sets),
            .entry_bits (entry_bits)
        )
        u_ram
        (
            .clk       (clk),
            .reset     (reset),
            .clear     (inval),
            .raddr     (raddr),
            .waddr     (waddr),
            .wen       (wr_en[w]),
            .wdata     (wdata),
            .rdata     (rdata[w]),
            .init_done (way_done[w])
        );
    end

    // All ways sweep in lockstep, but wait for every one of them anyway
    assign init_done = &way_done;

    // ==============================
    // Lookup pipeline
    // ==============================

    // Stage 0 addresses the RAMs, a lookup only counts once the sweep is over
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            vld_s1 <= 1'b0;
            vld_s2 <= 1'b0;
            vld_s3 <= 1'b0;
            vld_s4 <= 1'b0;
        end
        else
        begin
            vld_s1 <= lookup_en && init_done;
            vld_s2 <= vld_s1;
            vld_s3 <= vld_s2;
            vld_s4 <= vld_s3;
        end
    end

    always_ff @(posedge clk)
    begin
        va_s1 <= lookup_va;
        va_s2 <= va_s1;
    end

    // Stage 2 has the RAM data and registers the first half of the compare
    // A cleared entry or an empty slot sets the top bit, so it can never match
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < num_ways; w++)
        begin
            xor_q[w] <= {~(vld_s2 & rdata[w][entry_bits-1]),
                         rdata[w][entry_bits-2 -: tag_bits] ^
                         va_s2[va_page_bits-1 -: tag_bits]};
            pa_s3[w] <= rdata[w][pa_page_bits-1:0];
        end
    end

    // Stage 3 reduces each XOR word to a single hit bit
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < num_ways; w++)
        begin
            hit_vec[w] <= ~(|xor_q[w]);
            pa_s4[w]   <= pa_s3[w];
        end
    end

    // At most one way hits, so an AND-OR mux picks its page
    always_comb
    begin
        hit_pa = '0;
        for (int w = 0; w < num_ways; w++)
        begin
            hit_pa = hit_pa | (pa_s4[w] & {pa_page_bits{hit_vec[w]}});
        end
    end

    // Final stage registers the result four cycles after the request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lookup_valid <= 1'b0;
            lookup_miss  <= 1'b0;
        end
        else
        begin
            lookup_valid <= |hit_vec;
            lookup_miss  <= vld_s4 && !(|hit_vec);
        end
    end

    always_ff @(posedge clk)
    begin
        lookup_pa <= hit_pa;
    end

    // The fill side never places one page in two ways of a set
    a_single_hit: assert property (@(posedge clk) disable iff (reset)
        $onehot0(hit_vec))
        else $error("tlb_lookup_pipe saw more than one hitting way");

endmodule

// ==== design/tlb_pkg.sv ====
package tlb_pkg;

    // ==============================
    // Page index widths
    // ==============================

    // Pages have a fixed size, so every port carries page indices and
    // never full addresses
    localparam int va_page_bits = 24;
    localparam int pa_page_bits = 20;

    // Virtual page index as it arrives on the lookup and fill ports
    typedef logic [va_page_bits-1:0] va_page_t;

    // Physical page index as it is stored and returned on a hit
    typedef logic [pa_page_bits-1:0] pa_page_t;

    // ==============================
    // Fill FSM
    // ==============================

    // An insert moves through a victim request, the victim answer, one
    // write cycle and a short bubble before the next fill is taken
    typedef enum logic [2:0]
    {
        // Waiting for a fill request from the page walker
        fill_idle,
        // Asking the replacement logic for a victim way
        fill_req_way,
        // Waiting for the one-hot victim vector
        fill_recv_way,
        // Writing the entry into every lookup copy at once
        fill_insert,
        // Quiet cycles after the write
        fill_bubble
    } fill_state_t;

endpackage

// ==== design/tlb_repl_select.sv ====
`timescale 1ns/1ps

module tlb_repl_select
#(
    parameter int num_sets = 64,
    parameter int num_ways = 4
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        inval,
    input  logic                        repl_req,
    input  logic [$clog2(num_sets)-1:0] repl_idx,
    output logic                        repl_ack,
    output logic [num_ways-1:0]         repl_way_vec
);

    localparam int way_bits = $clog2(num_ways);

    typedef logic [num_ways-1:0] way_vec_t;

    // One bit per way per set, set once the way has been handed out
    way_vec_t    used [num_sets];
    logic [15:0] lfsr;
    way_vec_t    occ;
    way_vec_t    free_vec;
    way_vec_t    rand_vec;
    way_vec_t    pick_vec;

    // Free-running 16 bit Fibonacci LFSR with taps 16, 14, 13 and 11
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr <= 16'hace1;
        end
        else
        begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // Lowest clear bit of the occupancy vector, zero when the set is full
    assign occ      = used[repl_idx];
    assign free_vec = ~occ & (occ + 1'b1);
    assign rand_vec = way_vec_t'(1) << lfsr[way_bits-1:0];
    assign pick_vec = (|free_vec) ? free_vec : rand_vec;

    // Occupancy clears at once on reset or invalidate
    always_ff @(posedge clk)
    begin
        if (reset || inval)
        begin
            for (int s = 0; s < num_sets; s++)
            begin
                used[s] <= '0;
            end
        end
        else if (repl_req)
        begin
            used[repl_idx] <= occ | pick_vec;
        end
    end

    // Answer arrives the cycle after the request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            repl_ack <= 1'b0;
        end
        else
        begin
            repl_ack <= repl_req;
        end
    end

    always_ff @(posedge clk)
    begin
        if (repl_req)
        begin
            repl_way_vec <= pick_vec;
        end
    end

    // The fill FSM writes exactly the ways flagged here
    a_onehot_victim: assert property (@(posedge clk) disable iff (reset)
        repl_ack |-> $onehot(repl_way_vec))
        else $error("tlb_repl_select victim vector is not one-hot");

endmodule

// ==== design/tlb_top.sv ====
`timescale 1ns/1ps

module tlb_top
#(
    parameter int num_sets = 64,
    parameter int num_ways = 4
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              inval,
    input  logic              lookup_en_0,
    input  tlb_pkg::va_page_t lookup_va_0,
    input  logic              lookup_en_1,
    input  tlb_pkg::va_page_t lookup_va_1,
    input  logic              fill_en,
    input  tlb_pkg::va_page_t fill_va,
    input  tlb_pkg::pa_page_t fill_pa,
    output logic              lookup_rdy,
    output logic              lookup_valid_0,
    output logic              lookup_miss_0,
    output tlb_pkg::pa_page_t lookup_pa_0,
    output logic              lookup_valid_1,
    output logic              lookup_miss_1,
    output tlb_pkg::pa_page_t lookup_pa_1,
    output logic              fill_rdy
);

    import tlb_pkg::*;

    // Write bus shared by both lookup copies
    logic [num_ways-1:0] wr_en;
    va_page_t            wr_va;
    pa_page_t            wr_pa;

    logic init_done_0;
    logic init_done_1;

    // Both copies must finish their sweep before anything is accepted
    assign lookup_rdy = init_done_0 && init_done_1;

    // Port 0 copy
    tlb_lookup_pipe
    #(
        .num_sets (num_sets),
        .num_ways (num_ways)
    )
    u_pipe_0
    (
        .clk          (clk),
        .reset        (reset),
        .inval        (inval),
        .lookup_en    (lookup_en_0),
        .lookup_va    (lookup_va_0),
        .wr_en        (wr_en),
        .wr_va        (wr_va),
        .wr_pa        (wr_pa),
        .init_done    (init_done_0),
        .lookup_valid (lookup_valid_0),
        .lookup_miss  (lookup_miss_0),
        .lookup_pa    (lookup_pa_0)
    );

    // Port 1 copy, written with the same data in the same cycle
    tlb_lookup_pipe
    #(
        .num_sets (num_sets),
        .num_ways (num_ways)
    )
    u_pipe_1
    (
        .clk          (clk),
        .reset        (reset),
        .inval        (inval),
        .lookup_en    (lookup_en_1),
        .lookup_va    (lookup_va_1),
        .wr_en        (wr_en),
        .wr_va        (wr_va),
        .wr_pa        (wr_pa),
        .init_done    (init_done_1),
        .lookup_valid (lookup_valid_1),
        .lookup_miss  (lookup_miss_1),
        .lookup_pa    (lookup_pa_1)
    );

    tlb_fill_ctrl
    #(
        .num_sets (num_sets),
        .num_ways (num_ways)
    )
    u_fill
    (
        .clk       (clk),
        .reset     (reset),
        .inval     (inval),
        .init_done (lookup_rdy),
        .fill_en   (fill_en),
        .fill_va   (fill_va),
        .fill_pa   (fill_pa),
        .fill_rdy  (fill_rdy),
        .wr_en     (wr_en),
        .wr_va     (wr_va),
        .wr_pa     (wr_pa)
    );

endmodule

// ==== design/tlb_way_ram.sv ====
`timescale 1ns/1ps

module tlb_way_ram
#(
    parameter int num_sets   = 64,
    parameter int entry_bits = 39
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        clear,
    input  logic [$clog2(num_sets)-1:0] raddr,
    input  logic [$clog2(num_sets)-1:0] waddr,
    input  logic                        wen,
    input  logic [entry_bits-1:0]       wdata,
    output logic [entry_bits-1:0]       rdata,
    output logic                        init_done
);

    localparam int idx_bits = $clog2(num_sets);

    typedef logic [idx_bits-1:0]   idx_t;
    typedef logic [entry_bits-1:0] entry_t;

    // One entry per set for this way
    entry_t mem [num_sets];

    // First read register, the second one is rdata itself
    entry_t rd_stage;

    // Sweep position and busy flag
    idx_t sweep_idx;
    logic sweeping;

    // Reset or clear restarts the sweep from set zero
    // The last set written ends the sweep and raises init_done
    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
            init_done <= 1'b0;
        end
        else if (sweeping)
        begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == idx_t'(num_sets - 1))
            begin
                sweeping  <= 1'b0;
                init_done <= 1'b1;
            end
        end
    end

    // The sweep owns the write port until it is done
    always_ff @(posedge clk)
    begin
        if (sweeping)
        begin
            mem[sweep_idx] <= '0;
        end
        else if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Two registered read stages, so data shows up two cycles after raddr
    always_ff @(posedge clk)
    begin
        rd_stage <= mem[raddr];
        rdata    <= rd_stage;
    end

    // The fill side must hold off until every way has finished its sweep
    a_no_write_in_sweep: assert property (@(posedge clk) disable iff (reset)
        sweeping |-> !wen)
        else $error("tlb_way_ram write arrived during the clearing sweep");

endmodule

// ==== filelist.f ====
design/tlb_pkg.sv
design/tlb_way_ram.sv
design/tlb_repl_select.sv
design/tlb_lookup_pipe.sv
design/tlb_fill_ctrl.sv
design/tlb_top.sv
testbench/tb_tlb.sv

// ==== testbench/tb_tlb.sv ====
`timescale 1ns/1ps

module tb_tlb;

    import tlb_pkg::*;

    localparam int num_sets = 64;
    localparam int num_ways = 4;
    localparam int idx_bits = $clog2(num_sets);
    // A lookup driven on one falling edge shows its result five falling edges later
    localparam int result_delay = 5;

    logic     clk;
    logic     reset;
    logic     inval;
    logic     lookup_en_0;
    va_page_t lookup_va_0;
    logic     lookup_en_1;
    va_page_t lookup_va_1;
    logic     fill_en;
    va_page_t fill_va;
    pa_page_t fill_pa;
    logic     lookup_rdy;
    logic     lookup_valid_0;
    logic     lookup_miss_0;
    pa_page_t lookup_pa_0;
    logic     lookup_valid_1;
    logic     lookup_miss_1;
    pa_page_t lookup_pa_1;
    logic     fill_rdy;

    // ==============================
    // Reference model
    // ==============================

    // Live translations, and the pages of each set in fill order
    pa_page_t page_map [va_page_t];
    va_page_t set_pages [num_sets][$];
    va_page_t filled [$];

    // Expected result per issued cycle, packed as {probe, en, hit, pa}
    logic [22:0] exp_q0 [$];
    logic [22:0] exp_q1 [$];

    // Last probe result seen on port 0
    logic     probe_valid;
    pa_page_t probe_pa;

    int errors;
    int timeouts;

    tlb_top
    #(
        .num_sets (num_sets),
        .num_ways (num_ways)
    )
    uut
    (
        .clk            (clk),
        .reset          (reset),
        .inval          (inval),
        .lookup_en_0    (lookup_en_0),
        .lookup_va_0    (lookup_va_0),
        .lookup_en_1    (lookup_en_1),
        .lookup_va_1    (lookup_va_1),
        .fill_en        (fill_en),
        .fill_va        (fill_va),
        .fill_pa        (fill_pa),
        .lookup_rdy     (lookup_rdy),
        .lookup_valid_0 (lookup_valid_0),
        .lookup_miss_0  (lookup_miss_0),
        .lookup_pa_0    (lookup_pa_0),
        .lookup_valid_1 (lookup_valid_1),
        .lookup_miss_1  (lookup_miss_1),
        .lookup_pa_1    (lookup_pa_1),
        .fill_rdy       (fill_rdy)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("error %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic end_run();
        $display("tb_tlb finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // A hit carries the stored page, anything else is a miss
    function automatic logic [22:0] expect_entry(input logic en, input va_page_t va,
                                                 input logic probe);
        if (!en)
        begin
            return '0;
        end
        if (page_map.exists(va))
        begin
            return {probe, 1'b1, 1'b1, page_map[va]};
        end
        return {probe, 1'b1, 1'b0, 20'h0};
    endfunction

    // Probe entries only record the answer, since the evicted way is random
    task automatic check_port(input int p, input logic [22:0] e, input logic v,
                              input logic m, input pa_page_t pa);
        string sfx;
        sfx = (p == 0) ? "_0" : "_1";
        if (e[22])
        begin
            probe_valid = v;
            probe_pa    = pa;
            // An accepted lookup gives exactly one of hit and miss
            check_value({"lookup_valid", sfx, " ^ lookup_miss", sfx}, v ^ m, 1'b1);
        end
        else
        begin
            check_value({"lookup_valid", sfx}, v, e[21] & e[20]);
            check_value({"lookup_miss", sfx}, m, e[21] & !e[20]);
            if (e[21] && e[20])
            begin
                check_value({"lookup_pa", sfx}, pa, e[19:0]);
            end
        end
    endtask

    // One clock cycle: check the oldest result, then drive both lookup ports
    // A lookup only counts when lookup_rdy is high at the sampling edge
    task automatic step(input logic en0, input va_page_t va0, input logic en1,
                        input va_page_t va1, input logic probe);
        @(negedge clk);
        if (exp_q0.size() == result_delay)
        begin
            check_port(0, exp_q0.pop_front(), lookup_valid_0, lookup_miss_0, lookup_pa_0);
            check_port(1, exp_q1.pop_front(), lookup_valid_1, lookup_miss_1, lookup_pa_1);
        end
        lookup_en_0 = en0;
        lookup_va_0 = va0;
        lookup_en_1 = en1;
        lookup_va_1 = va1;
        exp_q0.push_back(expect_entry(en0 && lookup_rdy, va0, probe));
        exp_q1.push_back(expect_entry(en1 && lookup_rdy, va1, 1'b0));
    endtask

    function automatic logic watched(input int sel);
        return (sel == 0) ? lookup_rdy : fill_rdy;
    endfunction

    // Idle cycles until lookup_rdy (sel 0) or fill_rdy (sel 1) reaches the level
    task automatic wait_signal(input int sel, input logic level, input int limit);
        int cnt;
        cnt = 0;
        while (watched(sel) !== level && cnt < limit)
        begin
            step(1'b0, '0, 1'b0, '0, 1'b0);
            cnt++;
        end
        if (watched(sel) !== level)
        begin
            $display("timed out after %0d cycles waiting for %s to become %0d",
                     limit, (sel == 0) ? "lookup_rdy" : "fill_rdy", level);
            timeouts++;
            end_run();
        end
    endtask

    function automatic va_page_t rand_page();
        return va_page_t'($urandom());
    endfunction

    // New page that maps to set s and is not in the model yet
    function automatic va_page_t page_in_set(input int s);
        va_page_t va;
        do
        begin
            va = va_page_t'($urandom());
            va[idx_bits-1:0] = s[idx_bits-1:0];
        end
        while (page_map.exists(va));
        return va;
    endfunction

    // Half of the lookups go to pages that were filled at some point
    function automatic va_page_t mixed_page();
        if ($urandom_range(1) == 0 && filled.size() > 0)
        begin
            return filled[$urandom_range(filled.size() - 1)];
        end
        return rand_page();
    endfunction

    // The model takes the page once the fill is accepted
    task automatic fill_page(input va_page_t va, input pa_page_t pa);
        wait_signal(1, 1'b1, 50);
        fill_en = 1'b1;
        fill_va = va;
        fill_pa = pa;
        step(1'b0, '0, 1'b0, '0, 1'b0);
        fill_en = 1'b0;
        page_map[va] = pa;
        set_pages[int'(va[idx_bits-1:0])].push_back(va);
        filled.push_back(va);
        wait_signal(1, 1'b1, 50);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        va_page_t va;
        va_page_t old_pages [$];
        int       s;
        int       misses;
        int       slot;

        void'($urandom(32'hdc94c154));
        errors      = 0;
        timeouts    = 0;
        reset       = 1'b1;
        inval       = 1'b0;
        lookup_en_0 = 1'b0;
        lookup_va_0 = '0;
        lookup_en_1 = 1'b0;
        lookup_va_1 = '0;
        fill_en     = 1'b0;
        fill_va     = '0;
        fill_pa     = '0;
        repeat (10) @(negedge clk);

        // Outputs stay quiet while reset is held
        check_value("lookup_rdy", lookup_rdy, 1'b0);
        check_value("fill_rdy", fill_rdy, 1'b0);
        check_value("lookup_valid_0", lookup_valid_0, 1'b0);
        check_value("lookup_miss_0", lookup_miss_0, 1'b0);
        check_value("lookup_valid_1", lookup_valid_1, 1'b0);
        check_value("lookup_miss_1", lookup_miss_1, 1'b0);
        reset = 1'b0;

        // Lookups during the sweep are refused and give no result
        repeat (8) step(1'b1, rand_page(), 1'b1, rand_page(), 1'b0);

        // Empty TLB after the sweep, so every lookup misses
        wait_signal(0, 1'b1, num_sets + 20);
        wait_signal(1, 1'b1, num_sets + 20);
        repeat (20) step(1'b1, rand_page(), 1'b1, rand_page(), 1'b0);

        // Each fill is looked up on both ports right after fill_rdy returns
        for (int i = 0; i < 48; i++)
        begin
            s = $urandom_range(num_sets - 1);
            if (set_pages[s].size() < num_ways)
            begin
                va = page_in_set(s);
                fill_page(va, pa_page_t'($urandom()));
                step(1'b1, va, 1'b1, va, 1'b0);
            end
        end

        // Lookups every cycle on both ports, hits and misses mixed
        repeat (200) step(1'b1, mixed_page(), 1'b1, mixed_page(), 1'b0);

        // Fill one set to the brim, then one more page pushes an old one out
        s = $urandom_range(num_sets - 1);
        while (set_pages[s].size() < num_ways)
        begin
            fill_page(page_in_set(s), pa_page_t'($urandom()));
        end
        va = page_in_set(s);
        fill_page(va, pa_page_t'($urandom()));
        misses = 0;
        slot   = -1;
        for (int i = 0; i < num_ways; i++)
        begin
            step(1'b1, set_pages[s][i], 1'b0, '0, 1'b1);
            repeat (result_delay) step(1'b0, '0, 1'b0, '0, 1'b0);
            if (probe_valid)
            begin
                check_value("lookup_pa_0", probe_pa, page_map[set_pages[s][i]]);
            end
            else
            begin
                misses++;
                slot = i;
            end
        end
        check_value("evicted page count", misses, 1);
        if (slot >= 0)
        begin
            page_map.delete(set_pages[s][slot]);
            set_pages[s].delete(slot);
        end
        step(1'b1, va, 1'b1, va, 1'b0);

        // Invalidate pulse, the sweep must end and leave nothing behind
        repeat (result_delay) step(1'b0, '0, 1'b0, '0, 1'b0);
        old_pages = filled;
        inval = 1'b1;
        step(1'b0, '0, 1'b0, '0, 1'b0);
        inval = 1'b0;
        wait_signal(0, 1'b0, 4);
        wait_signal(0, 1'b1, num_sets + 20);
        page_map.delete();
        for (int i = 0; i < num_sets; i++)
        begin
            set_pages[i].delete();
        end
        filled.delete();
        foreach (old_pages[i])
        begin
            step(1'b1, old_pages[i], 1'b1, old_pages[i], 1'b0);
        end

        // Fills work again once the TLB is clear
        va = rand_page();
        fill_page(va, pa_page_t'($urandom()));
        step(1'b1, va, 1'b1, va, 1'b0);
        repeat (result_delay) step(1'b0, '0, 1'b0, '0, 1'b0);
        end_run();
    end

endmodule
